// ==== compile.f ====
hw/sort_pkg.sv
hw/xorshift16.sv
hw/record_gen.sv
hw/sort_net4.sv
hw/batch_ctrl.sv
hw/sorter_top.sv
verif/sorter_chk.sv
verif/tb_sorter.sv

// ==== Bender.yml ====
package:
  name: sorter

sources:
  - hw/sort_pkg.sv
  - hw/xorshift16.sv
  - hw/record_gen.sv
  - hw/sort_net4.sv
  - hw/batch_ctrl.sv
  - hw/sorter_top.sv
  - target: simulation
    files:
      - verif/sorter_chk.sv
      - verif/tb_sorter.sv

// ==== verif/tb_sorter.sv ====
`timescale 1ns/10ps

module tb_sorter import sort_pkg::*; ();

  localparam int NUM_BATCHES = 12;
  localparam int MAX_GAP     = 6;
  localparam int DRIVE_DLY   = 2;
  localparam int TIMEOUT_CYC = NUM_BATCHES * (BATCH_BEATS + NET_LAT + MAX_GAP + 8);

  logic              CLK;
  logic              RSTa;
  logic              i_start;
  mode_t             i_mode;
  sort_cfg_u         i_cfg;
  logic              o_valid;
  logic [BEAT_W-1:0] o_data;
  logic              o_done;
  logic              o_busy;

  logic [BEAT_W-1:0] exp_q[$];
  int                clk_cnt    = 0;
  int                neg_cnt    = 0;
  int                busy_lo    = 1;
  int                busy_hi    = 0;
  int                first_cyc  = 1;
  int                beats_seen = 0;

  sorter_top DUT (
    .CLK     (CLK),
    .RSTa    (RSTa),
    .i_start (i_start),
    .i_mode  (i_mode),
    .i_cfg   (i_cfg),
    .o_valid (o_valid),
    .o_data  (o_data),
    .o_done  (o_done),
    .o_busy  (o_busy)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  // ##################################################
  // reference model
  // ##################################################

  function automatic logic [KEY_W-1:0] xs_next(input logic [KEY_W-1:0] x);
    logic [KEY_W-1:0] y;
    y = x ^ (x << 7);
    y = y ^ (y >> 9);
    y = y ^ (y << 8);
    return y;
  endfunction

  // smallest key ends up in lane 0
  function automatic logic [BEAT_W-1:0] sort_keys(input logic [LANES-1:0][KEY_W-1:0] keys);
    logic [LANES-1:0][KEY_W-1:0] k;
    logic [KEY_W-1:0]            tmp;
    k = keys;
    for (int i = 0; i < LANES - 1; i++) begin
      for (int j = 0; j < LANES - 1 - i; j++) begin
        if (k[j] > k[j+1]) begin
          tmp    = k[j];
          k[j]   = k[j+1];
          k[j+1] = tmp;
        end
      end
    end
    return k;
  endfunction

  task automatic build_expected(input mode_t mode, input sort_cfg_u cfg);
    logic [LANES-1:0][KEY_W-1:0] xs;
    logic [LANES-1:0][KEY_W-1:0] keys;
    logic [KEY_W-1:0]            base;
    logic [KEY_W-1:0]            stride;
    base   = KEY_W'(cfg.ramp.base);
    stride = KEY_W'(cfg.ramp.stride);
    for (int k = 0; k < LANES; k++) begin
      xs[k] = cfg.seed ^ (KEY_W'(1) << k);
      if (xs[k] == '0) begin
        xs[k] = KEY_W'(1);
      end
    end
    for (int n = 0; n < BATCH_BEATS; n++) begin
      for (int k = 0; k < LANES; k++) begin
        // truncation to KEY_W gives the wrap
        case (mode)
          MODE_XORSHIFT: keys[k] = xs[k];
          MODE_REVERSE:  keys[k] = KEY_W'(base - k * stride - 4 * stride * n);
          default:       keys[k] = KEY_W'(base + k * stride + 4 * stride * n);
        endcase
        xs[k] = xs_next(xs[k]);
      end
      exp_q.push_back(sort_keys(keys));
    end
  endtask

  // ##################################################
  // output monitor
  // ##################################################

  always @(negedge CLK) begin
    logic exp_busy;
    logic exp_valid;
    logic exp_done;
    logic [BEAT_W-1:0] want;
    neg_cnt++;
    if (!RSTa) begin
      exp_busy  = (neg_cnt >= busy_lo) && (neg_cnt <= busy_hi);
      exp_valid = (neg_cnt >= first_cyc) && (neg_cnt <= busy_hi);
      exp_done  = (neg_cnt == busy_hi);
      assert (o_busy === exp_busy) else stop_on_error($sformatf(
        "Fail at %0t: o_busy is %b, expected %b", $time, o_busy, exp_busy));
      assert (o_valid === exp_valid) else stop_on_error($sformatf(
        "Fail at %0t: o_valid is %b, expected %b", $time, o_valid, exp_valid));
      assert (o_done === exp_done) else stop_on_error($sformatf(
        "Fail at %0t: o_done is %b, expected %b", $time, o_done, exp_done));
      if (o_valid === 1'b1) begin
        assert (exp_q.size() > 0) else stop_on_error(
          "An output beat arrived while no beat was expected");
        want = exp_q.pop_front();
        assert (o_data === want) else stop_on_error($sformatf(
          "Fail at %0t: beat %h, expected %h", $time, o_data, want));
        beats_seen++;
      end
      // accepted start opens a new timing window
      if (i_start && !exp_busy) begin
        busy_lo   = neg_cnt + 1;
        first_cyc = neg_cnt + 2 + NET_LAT;
        busy_hi   = first_cyc + BATCH_BEATS - 1;
      end
    end
  end

  always @(posedge CLK) begin
    clk_cnt++;
    if (clk_cnt > TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // ##################################################
  // stimulus
  // ##################################################

  task automatic run_batch(input mode_t mode, input sort_cfg_u cfg, input bit probe);
    build_expected(mode, cfg);
    @(posedge CLK);
    #DRIVE_DLY;
    i_mode  = mode;
    i_cfg   = cfg;
    i_start = 1'b1;
    @(posedge CLK);
    #DRIVE_DLY;
    i_start = 1'b0;
    if (probe) begin
      // a start mid batch with other settings is ignored
      repeat (10) @(posedge CLK);
      #DRIVE_DLY;
      i_mode     = mode_t'($urandom_range(0, 3));
      i_cfg.seed = KEY_W'($urandom);
      i_start    = 1'b1;
      @(posedge CLK);
      #DRIVE_DLY;
      i_start = 1'b0;
    end
    do begin
      @(negedge CLK);
    end while (o_done !== 1'b1);
  endtask

  initial begin
    sort_cfg_u cfg;
    mode_t     mode;
    int        gap;
    RSTa    = 1'b1;
    i_start = 1'b0;
    i_mode  = MODE_XORSHIFT;
    i_cfg   = '0;
    void'($urandom(32'h6d47));
    repeat (4) @(posedge CLK);
    #DRIVE_DLY;
    RSTa = 1'b0;
    // quiet stretch before the first start
    repeat (6) @(posedge CLK);
    for (int b = 0; b < NUM_BATCHES; b++) begin
      mode     = mode_t'($urandom_range(0, 3));
      cfg.seed = KEY_W'($urandom);
      case (b)
        0: begin
          // lane 2 seed comes out zero
          mode     = MODE_XORSHIFT;
          cfg.seed = 16'h0004;
        end
        1: begin
          mode            = MODE_SORTED;
          cfg.ramp.stride = 4'h0;
        end
        2: begin
          mode            = MODE_REVERSE;
          cfg.ramp.base   = 12'h005;
          cfg.ramp.stride = 4'hf;
        end
        3: begin
          mode            = MODE_SORTED;
          cfg.ramp.base   = 12'hfff;
          cfg.ramp.stride = 4'hf;
        end
        default: ;
      endcase
      gap = $urandom_range(0, MAX_GAP);
      run_batch(mode, cfg, (b == 5) || (b == 9));
      repeat (gap) @(posedge CLK);
    end
    repeat (NET_LAT + 2) @(posedge CLK);
    assert (exp_q.size() == 0) else stop_on_error(
      "Some expected beats never came out of the DUT");
    assert (beats_seen == NUM_BATCHES * BATCH_BEATS) else stop_on_error(
      "The total number of output beats is wrong");
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verif/sorter_chk.sv ====
`timescale 1ns/10ps

module sorter_chk import sort_pkg::*; (
  input logic              CLK,
  input logic              RSTa,
  input logic              i_valid,
  input logic [BEAT_W-1:0] i_data,
  input logic              i_done,
  input logic              i_busy
);

  logic ordered;

  always_comb begin
    ordered = 1'b1;
    for (int k = 0; k < LANES - 1; k++) begin
      if (i_data[k*KEY_W +: KEY_W] > i_data[(k+1)*KEY_W +: KEY_W]) begin
        ordered = 1'b0;
      end
    end
  end

  a_order: assert property (@(posedge CLK) disable iff (RSTa) i_valid |-> ordered)
    else $error("valid beat with keys out of ascending order");

  a_done_valid: assert property (@(posedge CLK) disable iff (RSTa) i_done |-> i_valid)
    else $error("done strobe without a valid beat");

  // nothing leaves while idle
  a_idle: assert property (@(posedge CLK) disable iff (RSTa) !i_busy |-> !i_valid && !i_done)
    else $error("valid or done while not busy");

  a_reset: assert property (@(posedge CLK) RSTa |=> !i_valid && !i_done && !i_busy)
    else $error("outputs not low after reset");

endmodule

bind sorter_top sorter_chk u_chk (
  .CLK     (CLK),
  .RSTa    (RSTa),
  .i_valid (o_valid),
  .i_data  (o_data),
  .i_done  (o_done),
  .i_busy  (o_busy)
);

// ==== hw/sorter_top.sv ====
`timescale 1ns/10ps

module sorter_top import sort_pkg::*; (
  input  logic              CLK,
  input  logic              RSTa,
  input  logic              i_start,
  input  mode_t             i_mode,
  input  sort_cfg_u         i_cfg,
  output logic              o_valid,
  output logic [BEAT_W-1:0] o_data,
  output logic              o_done,
  output logic              o_busy
);

  logic              gen_load;
  logic              gen_step;
  logic              gen_valid;
  logic [BEAT_W-1:0] gen_data;

  batch_ctrl u_ctrl (
    .CLK         (CLK),
    .RSTa        (RSTa),
    .i_start     (i_start),
    .i_out_valid (o_valid),
    .o_load      (gen_load),
    .o_step      (gen_step),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  record_gen u_gen (
    .CLK     (CLK),
    .RSTa    (RSTa),
    .i_load  (gen_load),
    .i_step  (gen_step),
    .i_mode  (i_mode),
    .i_cfg   (i_cfg),
    .o_valid (gen_valid),
    .o_data  (gen_data)
  );

  // sorted beats go out and back to the drain counter
  sort_net4 u_net (
    .CLK     (CLK),
    .RSTa    (RSTa),
    .i_valid (gen_valid),
    .i_data  (gen_data),
    .o_valid (o_valid),
    .o_data  (o_data)
  );

endmodule

// ==== hw/batch_ctrl.sv ====
`timescale 1ns/10ps

module batch_ctrl import sort_pkg::*; (
  input  logic CLK,
  input  logic RSTa,
  input  logic i_start,
  input  logic i_out_valid,
  output logic o_load,
  output logic o_step,
  output logic o_busy,
  output logic o_done
);

  logic [CNT_W-1:0] issued;
  logic [CNT_W-1:0] drained;
  logic             issue_more;
  logic             last_beat;

  assign issue_more = (issued < CNT_W'(BATCH_BEATS));
  assign last_beat  = (drained == CNT_W'(BATCH_BEATS - 1));

  // lands on the final beat leaving the network
  assign o_done = o_busy & i_out_valid & last_beat;

  // ##################################################
  // issue side
  // ##################################################

  always_ff @(posedge CLK) begin
    if (RSTa) begin
      o_load <= 1'b0;
      o_step <= 1'b0;
      o_busy <= 1'b0;
      issued <= '0;
    end else begin
      o_load <= 1'b0;
      o_step <= 1'b0;
      if (o_done) begin
        o_busy <= 1'b0;
      end
      if (i_start && !o_busy) begin
        // load counts as the first beat
        o_load <= 1'b1;
        o_busy <= 1'b1;
        issued <= CNT_W'(1);
      end else if (o_busy && issue_more) begin
        o_step <= 1'b1;
        issued <= issued + CNT_W'(1);
      end
    end
  end

  // ##################################################
  // drain side
  // ##################################################

  always_ff @(posedge CLK) begin
    if (RSTa) begin
      drained <= '0;
    end else if (o_done) begin
      drained <= '0;
    end else if (o_busy && i_out_valid) begin
      drained <= drained + CNT_W'(1);
    end
  end

endmodule

// ==== hw/sort_net4.sv ====
`timescale 1ns/10ps

module sort_net4 import sort_pkg::*; (
  input  logic              CLK,
  input  logic              RSTa,
  input  logic              i_valid,
  input  logic [BEAT_W-1:0] i_data,
  output logic              o_valid,
  output logic [BEAT_W-1:0] o_data
);

  logic [LANES-1:0][KEY_W-1:0] in_k;
  logic [LANES-1:0][KEY_W-1:0] st1_nxt;
  logic [LANES-1:0][KEY_W-1:0] st1_q;
  logic [LANES-1:0][KEY_W-1:0] st2_nxt;
  logic [LANES-1:0][KEY_W-1:0] st2_q;
  logic [LANES-1:0][KEY_W-1:0] st3_nxt;
  logic [LANES-1:0][KEY_W-1:0] st3_q;
  logic [NET_LAT-1:0]          vld_q;

  // returns {high, low}
  function automatic logic [2*KEY_W-1:0] cas(input logic [KEY_W-1:0] a,
                                              input logic [KEY_W-1:0] b);
    logic [2*KEY_W-1:0] res;
    if (a > b) begin
      res = {a, b};
    end else begin
      res = {b, a};
    end
    return res;
  endfunction

  assign in_k = i_data;

  // ##################################################
  // stage 1 compares pairs (0,1) and (2,3)
  // ##################################################

  always_comb begin
    {st1_nxt[1], st1_nxt[0]} = cas(in_k[0], in_k[1]);
    {st1_nxt[3], st1_nxt[2]} = cas(in_k[2], in_k[3]);
  end

  // ##################################################
  // stage 2 compares (0,2) and (1,3)
  // ##################################################

  // min and max now fixed in lanes 0 and 3
  always_comb begin
    {st2_nxt[2], st2_nxt[0]} = cas(st1_q[0], st1_q[2]);
    {st2_nxt[3], st2_nxt[1]} = cas(st1_q[1], st1_q[3]);
  end

  // ##################################################
  // stage 3 compares the middle pair
  // ##################################################

  always_comb begin
    st3_nxt    = st2_q;
    {st3_nxt[2], st3_nxt[1]} = cas(st2_q[1], st2_q[2]);
  end

  always_ff @(posedge CLK) begin
    if (RSTa) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[NET_LAT-2:0], i_valid};
    end
  end

  // data registers only move with a beat
  always_ff @(posedge CLK) begin
    if (i_valid) begin
      st1_q <= st1_nxt;
    end
    if (vld_q[0]) begin
      st2_q <= st2_nxt;
    end
    if (vld_q[1]) begin
      st3_q <= st3_nxt;
    end
  end

  assign o_valid = vld_q[NET_LAT-1];
  assign o_data  = st3_q;

endmodule

// ==== hw/record_gen.sv ====
`timescale 1ns/10ps

module record_gen import sort_pkg::*; (
  input  logic              CLK,
  input  logic              RSTa,
  input  logic              i_load,
  input  logic              i_step,
  input  mode_t             i_mode,
  input  sort_cfg_u         i_cfg,
  output logic              o_valid,
  output logic [BEAT_W-1:0] o_data
);

  mode_t            mode_q;
  mode_t            mode_eff;
  logic [3:0]       stride_q;
  logic [KEY_W-1:0] stride4;
  logic [KEY_W-1:0] ramp_base;
  logic             advance;
  logic             descend;
  logic             use_xs;
  wire [BEAT_W-1:0] beat_nxt;

  assign advance = i_load | i_step;

  // load uses the incoming mode, later steps the latched one
  assign mode_eff = i_load ? i_mode : mode_q;
  assign descend  = (mode_eff == MODE_REVERSE);
  assign use_xs   = (mode_eff == MODE_XORSHIFT);

  assign ramp_base = KEY_W'(i_cfg.ramp.base);
  assign stride4   = KEY_W'({stride_q, 2'b00});

  // ##################################################
  // per-lane sources
  // ##################################################

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    logic [KEY_W-1:0] lane_seed;
    logic [KEY_W-1:0] xs_value;
    logic [KEY_W-1:0] lane_off;
    logic [KEY_W-1:0] ramp_q;
    logic [KEY_W-1:0] ramp_nxt;

    // distinct seed per lane
    assign lane_seed = i_cfg.seed ^ (KEY_W'(1) << k);

    xorshift16 u_xs (
      .CLK     (CLK),
      .RSTa    (RSTa),
      .i_load  (i_load),
      .i_seed  (lane_seed),
      .i_step  (i_step),
      .o_value (xs_value)
    );

    assign lane_off = KEY_W'(k) * KEY_W'(i_cfg.ramp.stride);

    // ramps wrap modulo 2^16
    assign ramp_nxt = i_load ?
                      (descend ? ramp_base - lane_off : ramp_base + lane_off) :
                      (descend ? ramp_q - stride4 : ramp_q + stride4);

    always_ff @(posedge CLK) begin
      if (advance) begin
        ramp_q <= ramp_nxt;
      end
    end

    assign beat_nxt[k*KEY_W +: KEY_W] = use_xs ? xs_value : ramp_nxt;
  end

  // ##################################################
  // mode latch and output beat
  // ##################################################

  always_ff @(posedge CLK) begin
    if (RSTa) begin
      o_valid <= 1'b0;
      mode_q  <= MODE_XORSHIFT;
    end else begin
      o_valid <= advance;
      if (i_load) begin
        mode_q <= i_mode;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (i_load) begin
      stride_q <= i_cfg.ramp.stride;
    end
    if (advance) begin
      o_data <= beat_nxt;
    end
  end

endmodule

// ==== hw/xorshift16.sv ====
`timescale 1ns/10ps

module xorshift16 import sort_pkg::*; (
  input  logic             CLK,
  input  logic             RSTa,
  input  logic             i_load,
  input  logic [KEY_W-1:0] i_seed,
  input  logic             i_step,
  output logic [KEY_W-1:0] o_value
);

  logic [KEY_W-1:0] state;
  logic [KEY_W-1:0] state_nxt;
  logic [KEY_W-1:0] shuffled;

  // 7 / 9 / 8 shift triple
  always_comb begin
    shuffled = state ^ (state << 7);
    shuffled = shuffled ^ (shuffled >> 9);
    shuffled = shuffled ^ (shuffled << 8);
  end

  always_comb begin
    state_nxt = state;
    if (i_load) begin
      // zero is a fixed point of the shifts
      state_nxt = (i_seed == '0) ? KEY_W'(1) : i_seed;
    end else if (i_step) begin
      state_nxt = shuffled;
    end
  end

  always_ff @(posedge CLK) begin
    if (RSTa) begin
      state <= KEY_W'(1);
    end else begin
      state <= state_nxt;
    end
  end

  // caller registers the next state alongside
  assign o_value = state_nxt;

endmodule

// ==== hw/sort_pkg.sv ====
package sort_pkg;

  // ##################################################
  // widths and batch size
  // ##################################################

  localparam int KEY_W = 16;
  localparam int LANES = 4;

  // lane 0 sits in the low bits of a beat
  localparam int BEAT_W = KEY_W * LANES;

  localparam int BATCH_BEATS = 32;

  // one extra bit so a full batch count fits
  localparam int CNT_W = $clog2(BATCH_BEATS) + 1;

  // three compare-exchange stages
  localparam int NET_LAT = 3;

  // ##################################################
  // pattern modes
  // ##################################################

  typedef logic [1:0] mode_t;

  localparam mode_t MODE_XORSHIFT = 2'd0;
  localparam mode_t MODE_REVERSE  = 2'd1;
  // code 3 falls through to sorted
  localparam mode_t MODE_SORTED   = 2'd2;

  // ##################################################
  // configuration word
  // ##################################################

  // seed for xorshift, base and stride for the ramps
  typedef union packed {
    logic [KEY_W-1:0] seed;
    struct packed {
      logic [11:0] base;
      logic [3:0]  stride;
    } ramp;
  } sort_cfg_u;

endpackage
